/* src/nibbleCalcPkg.sv */
package nibbleCalcPkg;

    localparam int nibbleW = 4;  // operand and result width

    typedef logic [nibbleW-1:0] nibbleT;
    typedef logic [7:0] segT;    // active low, bit 7 is the decimal point

    // segment order is {dp, g, f, e, d, c, b, a}
    localparam segT segBlank = 8'b1111_1111;
    localparam segT segMinus = 8'b1011_1111;  // middle bar only
    localparam segT segF     = 8'b1000_1110;

    localparam segT segDigits [0:9] = '{
        8'b1100_0000,  // 0
        8'b1111_1001,  // 1
        8'b1010_0100,  // 2
        8'b1011_0000,  // 3
        8'b1001_1001,  // 4
        8'b1001_0010,  // 5
        8'b1000_0011,  // 6, drawn without the top bar
        8'b1111_1000,  // 7
        8'b1000_0000,  // 8
        8'b1001_1000   // 9
    };

    // encoded exactly as the two mode switches
    typedef enum logic [1:0] {
        modeIdle        = 2'b00,
        modeAddSub      = 2'b01,
        modeCmpUnsigned = 2'b10,
        modeCmpSigned   = 2'b11
    } modeT;

    // lamp positions on the board
    localparam int ledBGreater = 0;
    localparam int ledAGreater = 1;
    localparam int ledEqual    = 2;
    localparam int ledW        = 3;

endpackage

/* src/addSub.sv */
`timescale 1ns/1ns

module addSub (
    input  nibbleCalcPkg::nibbleT a,
    input  nibbleCalcPkg::nibbleT b,
    input  logic                  subtract,
    output nibbleCalcPkg::nibbleT sum,
    output logic                  overflow
);
    import nibbleCalcPkg::*;

    // carry[i] is the carry into bit i
    logic [nibbleW:0] carry;
    nibbleT           bOp;

    // A - B is done as A + ~B + 1
    assign bOp      = subtract ? ~b : b;
    assign carry[0] = subtract;

    for (genvar bitIdx = 0; bitIdx < nibbleW; bitIdx++) begin : gRipple
        // one full adder per bit
        assign sum[bitIdx] = a[bitIdx] ^ bOp[bitIdx] ^ carry[bitIdx];
        assign carry[bitIdx+1] = (a[bitIdx] & bOp[bitIdx])
                               | (a[bitIdx] & carry[bitIdx])
                               | (bOp[bitIdx] & carry[bitIdx]);
    end

    // signed result out of -8..7 when carries into and out of the sign bit differ
    assign overflow = carry[nibbleW] ^ carry[nibbleW-1];

endmodule

/* src/magCompare.sv */
`timescale 1ns/1ns

module magCompare (
    input  nibbleCalcPkg::nibbleT a,
    input  nibbleCalcPkg::nibbleT b,
    input  nibbleCalcPkg::modeT   mode,
    output logic                  aGreater,
    output logic                  bGreater,
    output logic                  equal
);
    import nibbleCalcPkg::*;

    logic signedCmp;

    assign signedCmp = (mode == modeCmpSigned);

    // first differing bit from the top decides
    always_comb begin
        aGreater = 1'b0;
        bGreater = 1'b0;
        equal    = 1'b1;  // doubles as "no difference found yet"
        for (int i = nibbleW - 1; i >= 0; i--) begin
            if (equal && (a[i] != b[i])) begin
                equal = 1'b0;
                if (signedCmp && (i == nibbleW - 1)) begin
                    // sign bits differ, the negative one is smaller
                    aGreater = b[i];
                    bGreater = a[i];
                end else begin
                    aGreater = a[i];
                    bGreater = b[i];
                end
            end
        end
    end

endmodule

/* src/numberDisplay.sv */
`timescale 1ns/1ns

module numberDisplay (
    input  nibbleCalcPkg::nibbleT value,
    input  nibbleCalcPkg::modeT   mode,
    output nibbleCalcPkg::segT    tensSeg,
    output nibbleCalcPkg::segT    onesSeg
);
    import nibbleCalcPkg::*;

    logic   negative;
    nibbleT magnitude;
    logic   twoDigit;
    nibbleT unsignedOnes;

    // two's complement view
    assign negative  = value[nibbleW-1];
    assign magnitude = negative ? nibbleT'(-value) : value;  // -8 wraps to 4'b1000, shown as 8

    // unsigned view, 0..15
    assign twoDigit     = (value > nibbleT'(9));
    assign unsignedOnes = twoDigit ? nibbleT'(value - nibbleT'(10)) : value;

    always_comb begin
        if (mode == modeCmpUnsigned) begin
            tensSeg = twoDigit ? segDigits[1] : segBlank;
            onesSeg = segDigits[unsignedOnes];
        end else begin
            tensSeg = negative ? segMinus : segBlank;  // sign goes in the tens place
            onesSeg = segDigits[magnitude];
        end
    end

endmodule

/* src/nibbleCalcTop.sv */
`timescale 1ns/1ns

module nibbleCalcTop (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [9:0]                          sw,
    input  logic                                key,   // active low button
    output nibbleCalcPkg::segT                  hex0,
    output nibbleCalcPkg::segT                  hex1,
    output nibbleCalcPkg::segT                  hex2,
    output nibbleCalcPkg::segT                  hex3,
    output nibbleCalcPkg::segT                  hex4,
    output nibbleCalcPkg::segT                  hex5,
    output logic [nibbleCalcPkg::ledW-1:0]      ledr
);
    import nibbleCalcPkg::*;

    // stage 1, sampled inputs
    nibbleT opA;
    nibbleT opB;
    modeT   mode;
    logic   subtract;

    // combinational results between the stages
    nibbleT sum;
    logic   overflow;
    logic   aGreater;
    logic   bGreater;
    logic   equal;
    segT    aTens;
    segT    aOnes;
    segT    bTens;
    segT    bOnes;
    segT    resTens;
    segT    resOnes;

    // next values for the output register
    segT             hexNext [0:5];
    logic [ledW-1:0] ledNext;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            opA      <= '0;
            opB      <= '0;
            mode     <= modeIdle;
            subtract <= 1'b0;
        end else begin
            opA      <= sw[7:4];
            opB      <= sw[3:0];
            mode     <= modeT'(sw[9:8]);
            subtract <= ~key;  // pressed means A minus B
        end
    end

    addSub addSub_i (
        .a        (opA),
        .b        (opB),
        .subtract (subtract),
        .sum      (sum),
        .overflow (overflow)
    );

    magCompare magCompare_i (
        .a        (opA),
        .b        (opB),
        .mode     (mode),
        .aGreater (aGreater),
        .bGreater (bGreater),
        .equal    (equal)
    );

    numberDisplay dispA (
        .value   (opA),
        .mode    (mode),
        .tensSeg (aTens),
        .onesSeg (aOnes)
    );

    numberDisplay dispB (
        .value   (opB),
        .mode    (mode),
        .tensSeg (bTens),
        .onesSeg (bOnes)
    );

    numberDisplay dispResult (
        .value   (sum),
        .mode    (mode),
        .tensSeg (resTens),
        .onesSeg (resOnes)
    );

    always_comb begin
        for (int i = 0; i < 6; i++) begin
            hexNext[i] = segBlank;
        end
        ledNext = '0;
        case (mode)
            modeAddSub: begin
                hexNext[5] = aTens;
                hexNext[4] = aOnes;
                hexNext[3] = bTens;
                hexNext[2] = bOnes;
                if (overflow) begin  // shows "0F"
                    hexNext[1] = segDigits[0];
                    hexNext[0] = segF;
                end else begin
                    hexNext[1] = resTens;
                    hexNext[0] = resOnes;
                end
            end
            modeCmpUnsigned, modeCmpSigned: begin
                hexNext[5] = aTens;
                hexNext[4] = aOnes;
                hexNext[3] = bTens;
                hexNext[2] = bOnes;
                ledNext[ledAGreater] = aGreater;
                ledNext[ledBGreater] = bGreater;
                ledNext[ledEqual]    = equal;
            end
            default: ;  // idle leaves everything dark
        endcase
    end

    // stage 2, output register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hex0 <= segBlank;
            hex1 <= segBlank;
            hex2 <= segBlank;
            hex3 <= segBlank;
            hex4 <= segBlank;
            hex5 <= segBlank;
            ledr <= '0;
        end else begin
            hex0 <= hexNext[0];
            hex1 <= hexNext[1];
            hex2 <= hexNext[2];
            hex3 <= hexNext[3];
            hex4 <= hexNext[4];
            hex5 <= hexNext[5];
            ledr <= ledNext;
        end
    end

endmodule

/* dv/clockGen.sv */
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic rstN
);

    // 8 ns period, first rising edge at 4 ns
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset held low over the first five rising edges
    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        #1 rstN = 1'b1;  // released just after the edge like other stimulus
    end

endmodule

/* dv/nibbleCalcTb.sv */
`timescale 1ns/1ns

module nibbleCalcTb;
    import nibbleCalcPkg::*;

    localparam int outW = 6 * 8 + ledW;        // six digits and the lamps, packed
    localparam logic [31:0] lcgSeed = 32'h59ff_0775;
    // sweeps take 4 x 256 x 2 cycles, the pipeline run about 500 more, reset about 10
    localparam int cycleLimit = 10000;

    localparam logic [outW-1:0] allBlank = {
        segBlank, segBlank, segBlank, segBlank, segBlank, segBlank, {ledW{1'b0}}
    };

    logic            clk;
    logic            rstN;
    logic [9:0]      sw;
    logic            key;
    segT             hex0;
    segT             hex1;
    segT             hex2;
    segT             hex3;
    segT             hex4;
    segT             hex5;
    logic [ledW-1:0] ledr;

    int cycleCount = 0;

    clockGen clockGen_i (
        .clk  (clk),
        .rstN (rstN)
    );

    nibbleCalcTop nibbleCalcTop_i (
        .clk  (clk),
        .rstN (rstN),
        .sw   (sw),
        .key  (key),
        .hex0 (hex0),
        .hex1 (hex1),
        .hex2 (hex2),
        .hex3 (hex3),
        .hex4 (hex4),
        .hex5 (hex5),
        .ledr (ledr)
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout, tests still running after %0d cycles", cycleLimit);
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // four switch bits read as two's complement
    function automatic int nibbleSigned(input logic [3:0] n);
        int v;
        v = int'(n);
        if (n[3]) begin
            v = v - 16;
        end
        return v;
    endfunction

    // {tens, ones} for -8..7, sign in the tens place
    function automatic logic [15:0] signedDigits(input int value);
        int  mag;
        segT tens;
        mag  = (value < 0) ? -value : value;
        tens = (value < 0) ? segMinus : segBlank;
        return {tens, segDigits[mag]};
    endfunction

    // {tens, ones} for 0..15
    function automatic logic [15:0] unsignedDigits(input int value);
        segT tens;
        tens = (value >= 10) ? segDigits[1] : segBlank;
        return {tens, segDigits[value % 10]};
    endfunction

    function automatic logic [ledW-1:0] compareLamps(input int a, input int b);
        logic [ledW-1:0] lamps;
        lamps = '0;
        lamps[ledAGreater] = (a > b);
        lamps[ledBGreater] = (b > a);
        lamps[ledEqual]    = (a == b);
        return lamps;
    endfunction

    // expected {hex5 .. hex0, ledr} for one sample of the switches and button
    function automatic logic [outW-1:0] modelOutputs(input logic [9:0] swVal,
                                                     input logic keyVal);
        int              aS;
        int              bS;
        int              aU;
        int              bU;
        int              res;
        logic [15:0]     aDisp;
        logic [15:0]     bDisp;
        logic [15:0]     resDisp;
        logic [ledW-1:0] ledVal;
        aU      = int'(swVal[7:4]);
        bU      = int'(swVal[3:0]);
        aS      = nibbleSigned(swVal[7:4]);
        bS      = nibbleSigned(swVal[3:0]);
        aDisp   = {segBlank, segBlank};
        bDisp   = {segBlank, segBlank};
        resDisp = {segBlank, segBlank};
        ledVal  = '0;
        case (modeT'(swVal[9:8]))
            modeAddSub: begin
                aDisp = signedDigits(aS);
                bDisp = signedDigits(bS);
                res   = keyVal ? aS + bS : aS - bS;  // released button adds
                if (res < -8 || res > 7) begin
                    resDisp = {segDigits[0], segF};
                end else begin
                    resDisp = signedDigits(res);
                end
            end
            modeCmpUnsigned: begin
                aDisp  = unsignedDigits(aU);
                bDisp  = unsignedDigits(bU);
                ledVal = compareLamps(aU, bU);
            end
            modeCmpSigned: begin
                aDisp  = signedDigits(aS);
                bDisp  = signedDigits(bS);
                ledVal = compareLamps(aS, bS);
            end
            default: ;  // idle, all dark
        endcase
        return {aDisp, bDisp, resDisp, ledVal};
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic driveInputs(input logic [9:0] swVal, input logic keyVal);
        sw  = swVal;
        key = keyVal;
    endtask

    task automatic checkOutputs(input string testName, input logic [outW-1:0] expected);
        logic [outW-1:0] actual;
        actual = {hex5, hex4, hex3, hex2, hex1, hex0, ledr};
        assert (actual === expected) else begin
            $display("CHECK FAILED: %s expected %h actual %h", testName, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // every operand pair, held two cycles so the result clears both stages
    task automatic sweepPairs(input string testName, input modeT modeVal, input logic keyVal);
        logic [3:0] aVal;
        logic [3:0] bVal;
        logic [9:0] swVal;
        for (int a = 0; a < 16; a++) begin
            for (int b = 0; b < 16; b++) begin
                aVal  = a[3:0];
                bVal  = b[3:0];
                swVal = {modeVal, aVal, bVal};
                driveInputs(swVal, keyVal);
                nextCycle();
                nextCycle();
                checkOutputs(testName, modelOutputs(swVal, keyVal));
            end
        end
    endtask

    task automatic testReset();
        driveInputs({modeAddSub, 4'h7, 4'h5}, 1'b0);  // busy inputs while in reset
        @(posedge clk);
        @(posedge clk);
        #1;
        checkOutputs("testReset", allBlank);
        wait (rstN === 1'b1);
        nextCycle();
        checkOutputs("testReset", allBlank);  // stage 1 still holds idle
        driveInputs({modeIdle, 4'hA, 4'h6}, 1'b0);
        nextCycle();
        nextCycle();
        checkOutputs("testReset", allBlank);
    endtask

    task automatic testAdd();
        sweepPairs("testAdd", modeAddSub, 1'b1);
    endtask

    task automatic testSubtract();
        sweepPairs("testSubtract", modeAddSub, 1'b0);
    endtask

    task automatic testCompareUnsigned();
        sweepPairs("testCompareUnsigned", modeCmpUnsigned, 1'b1);
    endtask

    task automatic testCompareSigned();
        sweepPairs("testCompareSigned", modeCmpSigned, 1'b1);
    endtask

    // new inputs every cycle, outputs checked against the sample two cycles back
    task automatic testPipeline();
        logic [31:0] lcgState;
        logic [9:0]  swVal;
        logic        keyVal;
        logic [9:0]  swOld;
        logic        keyOld;
        logic [9:0]  swQueue [$];
        logic        keyQueue [$];
        lcgState = lcgSeed;
        for (int i = 0; i < 502; i++) begin
            if (i >= 2) begin
                swOld  = swQueue.pop_front();
                keyOld = keyQueue.pop_front();
                checkOutputs("testPipeline", modelOutputs(swOld, keyOld));
            end
            if (i < 500) begin
                lcgState = nextRandom(lcgState);
                swVal    = lcgState[25:16];  // upper bits, low LCG bits repeat quickly
                keyVal   = lcgState[31];
                driveInputs(swVal, keyVal);
                swQueue.push_back(swVal);
                keyQueue.push_back(keyVal);
            end
            nextCycle();
        end
    endtask

    initial begin
        sw  = '0;
        key = 1'b1;
        testReset();
        testAdd();
        testSubtract();
        testCompareUnsigned();
        testCompareSigned();
        testPipeline();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* nibbleCalc.f */
src/nibbleCalcPkg.sv
src/addSub.sv
src/magCompare.sv
src/numberDisplay.sv
src/nibbleCalcTop.sv
dv/clockGen.sv
dv/nibbleCalcTb.sv

/* runSim.sh */
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module nibbleCalcTb \
    -f nibbleCalc.f \
    -o nibbleCalcSim

./obj_dir/nibbleCalcSim
